/* logic/apple1EmuPkg.sv */
// Shared types and constants for the Apple-1 emulation shell.
// Imported by every block that talks to the host port, the PIA or the memory.
package apple1EmuPkg;

    typedef logic [7:0]  byteT;
    typedef logic [15:0] cpuAddrT;
    typedef logic [2:0]  hostAddrT;

    // PIA register map
    localparam cpuAddrT PIA_KBD_REG = 16'hD010;
    localparam cpuAddrT PIA_KBD_CTL = 16'hD011;
    localparam cpuAddrT PIA_DSP_REG = 16'hD012;

    localparam int NUM_STIM = 6;
    localparam int NUM_OUT  = 4;

    // Stimulus slots written by the host
    localparam int STIM_CTRL      = 0;
    localparam int STIM_KBD       = 1;
    localparam int STIM_MEMCTL    = 2;
    localparam int STIM_MEMADDRHI = 3;
    localparam int STIM_MEMADDRLO = 4;
    localparam int STIM_MEMDATA   = 5;

    localparam int CTRL_KBDWR = 4; // Bits in STIM_CTRL
    localparam int CTRL_DSPRD = 5;
    localparam int MEM_ENA    = 0; // Bits in STIM_MEMCTL
    localparam int MEM_WEN    = 1;

    // Result slots captured on get
    localparam int OUT_DSP    = 0;
    localparam int OUT_KBD    = 1;
    localparam int OUT_KBDCTL = 2;
    localparam int OUT_MEM    = 3;

    localparam int KBD_READY_BIT = 7;

    // One-hot display states
    typedef enum logic [2:0] {
        sReady       = 3'b001,
        sWaitDspAck  = 3'b010,
        sCheckDspAcc = 3'b100
    } dspStateT;

endpackage

/* logic/hostTransactor.sv */
// Host side of the emulation shell. Collects stimulus bytes through the
// addressed port, drives them out on hostLoad and captures results on hostGet.
`timescale 1ns/10ps

module hostTransactor (
    input  logic                   clk_dut,
    input  logic                   reset,
    input  apple1EmuPkg::hostAddrT hostAddr,
    input  apple1EmuPkg::byteT     hostDin,
    input  logic                   hostLoad,
    input  logic                   hostGet,
    output apple1EmuPkg::byteT     hostDout,
    output logic                   kbdWr,
    output logic                   dspRd,
    output apple1EmuPkg::byteT     kbdIn,
    output logic                   memHostEna,
    output logic                   memHostWen,
    output apple1EmuPkg::cpuAddrT  memHostAddr,
    output apple1EmuPkg::byteT     memHostData,
    input  apple1EmuPkg::byteT     dspReg,
    input  apple1EmuPkg::byteT     kbdReg,
    input  apple1EmuPkg::byteT     kbdCtl,
    input  apple1EmuPkg::byteT     memData
);
    import apple1EmuPkg::*;

    byteT stimIn [NUM_STIM];
    byteT vectOut [NUM_OUT];

    always_ff @(posedge clk_dut or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_STIM; i++)
            begin
                stimIn[i] <= '0;
            end
            kbdWr       <= 1'b0;
            dspRd       <= 1'b0;
            kbdIn       <= '0;
            memHostEna  <= 1'b0;
            memHostWen  <= 1'b0;
            memHostAddr <= '0;
            memHostData <= '0;
            hostDout    <= '0;
        end
        else if (hostLoad)
        begin
            kbdWr       <= stimIn[STIM_CTRL][CTRL_KBDWR];
            dspRd       <= stimIn[STIM_CTRL][CTRL_DSPRD];
            kbdIn       <= stimIn[STIM_KBD];
            memHostEna  <= stimIn[STIM_MEMCTL][MEM_ENA];
            memHostWen  <= stimIn[STIM_MEMCTL][MEM_WEN];
            memHostAddr <= {stimIn[STIM_MEMADDRHI], stimIn[STIM_MEMADDRLO]};
            memHostData <= stimIn[STIM_MEMDATA];
        end
        else if (!hostGet)
        begin
            if (hostAddr < NUM_STIM)
            begin
                stimIn[hostAddr] <= hostDin;
            end
            hostDout <= (hostAddr < NUM_OUT) ? vectOut[hostAddr[1:0]] : '0; // Upper slots read 0
        end
    end

    // Result snapshot
    always_ff @(posedge clk_dut)
    begin
        if (hostGet && !hostLoad)
        begin
            vectOut[OUT_DSP]    <= dspReg;
            vectOut[OUT_KBD]    <= kbdReg;
            vectOut[OUT_KBDCTL] <= kbdCtl;
            vectOut[OUT_MEM]    <= memData;
        end
    end

    loadGetExclusive: assert property (@(posedge clk_dut) disable iff (reset)
        !(hostLoad && hostGet));

endmodule

/* logic/piaBusDecode.sv */
// PIA address decode and CPU read-data multiplexer.
// Selects are registered so they line up with the registered memory word.
`timescale 1ns/10ps

module piaBusDecode (
    input  logic                  clk_dut,
    input  logic                  reset,
    input  apple1EmuPkg::cpuAddrT cpuAddr,
    input  apple1EmuPkg::byteT    kbdReg,
    input  apple1EmuPkg::byteT    kbdCtl,
    input  apple1EmuPkg::byteT    dspReg,
    input  apple1EmuPkg::byteT    memData,
    output apple1EmuPkg::byteT    cpuDataIn
);
    import apple1EmuPkg::*;

    logic kbdRegSel;
    logic kbdCtlSel;
    logic dspRegSel;

    always_ff @(posedge clk_dut or posedge reset)
    begin
        if (reset)
        begin
            kbdRegSel <= 1'b0;
            kbdCtlSel <= 1'b0;
            dspRegSel <= 1'b0;
        end
        else
        begin
            kbdRegSel <= (cpuAddr == PIA_KBD_REG);
            kbdCtlSel <= (cpuAddr == PIA_KBD_CTL);
            dspRegSel <= (cpuAddr == PIA_DSP_REG);
        end
    end

    always_comb
    begin
        if (kbdRegSel)
            cpuDataIn = kbdReg;
        else if (kbdCtlSel)
            cpuDataIn = kbdCtl;
        else if (dspRegSel)
            cpuDataIn = dspReg;
        else
            cpuDataIn = memData; // Plain memory access
    end

    selOneHot: assert property (@(posedge clk_dut) disable iff (reset)
        $onehot0({kbdRegSel, kbdCtlSel, dspRegSel}));

endmodule

/* logic/keyboardPort.sv */
// Keyboard half of the PIA. A host-raised key strobe is synchronised and
// turned into a single set pulse that latches the key and flags it ready.
`timescale 1ns/10ps

module keyboardPort (
    input  logic                  clk_dut,
    input  logic                  reset,
    input  logic                  kbdWr,
    input  apple1EmuPkg::byteT    kbdIn,
    input  apple1EmuPkg::cpuAddrT cpuAddr,
    input  logic                  cpuWe,
    output apple1EmuPkg::byteT    kbdReg,
    output apple1EmuPkg::byteT    kbdCtl
);
    import apple1EmuPkg::*;

    logic kbdWrSync0;
    logic kbdWrSync1;
    logic setKbd;
    logic kbdReady;

    always_ff @(posedge clk_dut or posedge reset)
    begin
        if (reset)
        begin
            kbdWrSync0 <= 1'b0;
            kbdWrSync1 <= 1'b0;
            setKbd     <= 1'b0;
        end
        else
        begin
            kbdWrSync0 <= kbdWr;
            kbdWrSync1 <= kbdWrSync0;
            setKbd     <= kbdWrSync0 && !kbdWrSync1; // Rising edge only
        end
    end

    always_ff @(posedge clk_dut or posedge reset)
    begin
        if (reset)
        begin
            kbdReg   <= '0;
            kbdReady <= 1'b0;
        end
        else if (setKbd)
        begin
            kbdReg   <= kbdIn;
            kbdReady <= 1'b1;
        end
        else if (cpuAddr == PIA_KBD_REG && !cpuWe)
        begin
            kbdReady <= 1'b0; // Key consumed
        end
    end

    always_comb
    begin
        kbdCtl = '0;
        kbdCtl[KBD_READY_BIT] = kbdReady;
    end

    setSingleShot: assert property (@(posedge clk_dut) disable iff (reset)
        setKbd |=> !setKbd);

endmodule

/* logic/displayPort.sv */
// Display half of the PIA. Holds one character written by the CPU until the
// host has seen dspRd go high and low again, then clears it.
`timescale 1ns/10ps

module displayPort (
    input  logic                  clk_dut,
    input  logic                  reset,
    input  apple1EmuPkg::cpuAddrT cpuAddr,
    input  apple1EmuPkg::byteT    cpuDataOut,
    input  logic                  cpuWe,
    input  logic                  dspRd,
    output apple1EmuPkg::byteT    dspReg
);
    import apple1EmuPkg::*;

    dspStateT dspState;

    always_ff @(posedge clk_dut or posedge reset)
    begin
        if (reset)
        begin
            dspState <= sReady;
            dspReg   <= '0;
        end
        else
        begin
            case (dspState)
                sReady:
                begin
                    if (cpuWe && cpuAddr == PIA_DSP_REG)
                    begin
                        dspReg   <= cpuDataOut;
                        dspState <= sWaitDspAck;
                    end
                end
                sWaitDspAck:
                begin
                    if (dspRd)
                        dspState <= sCheckDspAcc; // Host has started reading
                end
                sCheckDspAcc:
                begin
                    if (!dspRd)
                    begin
                        dspReg   <= '0;
                        dspState <= sReady;
                    end
                end
                default:
                    dspState <= sReady;
            endcase
        end
    end

    legalDspState: assert property (@(posedge clk_dut) disable iff (reset)
        dspState inside {sReady, sWaitDspAck, sCheckDspAcc});

endmodule

/* logic/emuMemory.sv */
// 64 KB byte memory shared by the CPU bus and the host.
// The host path takes over completely while memHostEna is high.
`timescale 1ns/10ps

module emuMemory (
    input  logic                  clk_dut,
    input  logic                  memHostEna,
    input  logic                  memHostWen,
    input  apple1EmuPkg::cpuAddrT memHostAddr,
    input  apple1EmuPkg::byteT    memHostData,
    input  apple1EmuPkg::cpuAddrT cpuAddr,
    input  apple1EmuPkg::byteT    cpuDataOut,
    input  logic                  cpuWe,
    output apple1EmuPkg::byteT    memData
);
    import apple1EmuPkg::*;

    byteT    mem [65536];
    cpuAddrT memAddr;
    byteT    memDin;
    logic    memWe;

    always_comb
    begin
        memAddr = memHostEna ? memHostAddr : cpuAddr;
        memDin  = memHostEna ? memHostData : cpuDataOut;
        memWe   = memHostEna ? memHostWen  : cpuWe;
    end

    // Read word holds its value during writes
    always_ff @(posedge clk_dut)
    begin
        if (memWe)
            mem[memAddr] <= memDin;
        else
            memData <= mem[memAddr];
    end

endmodule

/* logic/apple1EmuTop.sv */
// Top of the emulation shell. The CPU bus is brought out as ports so an
// external model can act as the processor; the host port loads and reads back.
`timescale 1ns/10ps

module apple1EmuTop (
    input  logic                   clk_dut,
    input  logic                   reset,
    input  apple1EmuPkg::hostAddrT hostAddr,
    input  apple1EmuPkg::byteT     hostDin,
    input  logic                   hostLoad,
    input  logic                   hostGet,
    output apple1EmuPkg::byteT     hostDout,
    input  apple1EmuPkg::cpuAddrT  cpuAddr,
    input  apple1EmuPkg::byteT     cpuDataOut,
    input  logic                   cpuWe,
    output apple1EmuPkg::byteT     cpuDataIn
);
    import apple1EmuPkg::*;

    logic    kbdWr;
    logic    dspRd;
    byteT    kbdIn;
    logic    memHostEna;
    logic    memHostWen;
    cpuAddrT memHostAddr;
    byteT    memHostData;
    byteT    kbdReg;
    byteT    kbdCtl;
    byteT    dspReg;
    byteT    memData;

    hostTransactor uHost (
        .clk_dut     (clk_dut),
        .reset       (reset),
        .hostAddr    (hostAddr),
        .hostDin     (hostDin),
        .hostLoad    (hostLoad),
        .hostGet     (hostGet),
        .hostDout    (hostDout),
        .kbdWr       (kbdWr),
        .dspRd       (dspRd),
        .kbdIn       (kbdIn),
        .memHostEna  (memHostEna),
        .memHostWen  (memHostWen),
        .memHostAddr (memHostAddr),
        .memHostData (memHostData),
        .dspReg      (dspReg),
        .kbdReg      (kbdReg),
        .kbdCtl      (kbdCtl),
        .memData     (memData)
    );

    piaBusDecode uDecode (
        .clk_dut   (clk_dut),
        .reset     (reset),
        .cpuAddr   (cpuAddr),
        .kbdReg    (kbdReg),
        .kbdCtl    (kbdCtl),
        .dspReg    (dspReg),
        .memData   (memData),
        .cpuDataIn (cpuDataIn)
    );

    keyboardPort uKbd (
        .clk_dut (clk_dut),
        .reset   (reset),
        .kbdWr   (kbdWr),
        .kbdIn   (kbdIn),
        .cpuAddr (cpuAddr),
        .cpuWe   (cpuWe),
        .kbdReg  (kbdReg),
        .kbdCtl  (kbdCtl)
    );

    displayPort uDsp (
        .clk_dut    (clk_dut),
        .reset      (reset),
        .cpuAddr    (cpuAddr),
        .cpuDataOut (cpuDataOut),
        .cpuWe      (cpuWe),
        .dspRd      (dspRd),
        .dspReg     (dspReg)
    );

    emuMemory uMem (
        .clk_dut     (clk_dut),
        .memHostEna  (memHostEna),
        .memHostWen  (memHostWen),
        .memHostAddr (memHostAddr),
        .memHostData (memHostData),
        .cpuAddr     (cpuAddr),
        .cpuDataOut  (cpuDataOut),
        .cpuWe       (cpuWe),
        .memData     (memData)
    );

endmodule

/* tests/apple1EmuTb.sv */
// Testbench for the Apple-1 emulation shell. Reads host and CPU operations
// from the stimulus file, acts as both the host and the CPU, and checks
// readback and bus data against the expected column of each line.
`timescale 1ns/10ps

module apple1EmuTb;
    import apple1EmuPkg::*;

    localparam int       CLK_PERIOD     = 40; // ns
    localparam int       RESET_CYCLES   = 4;
    localparam int       CYCLES_PER_OP  = 20; // Watchdog budget per file line
    localparam hostAddrT IDLE_SLOT      = 3'd7; // Ignored on write, reads zero
    localparam cpuAddrT  IDLE_ADDR      = 16'h0000;

    typedef enum {OP_HSET, OP_HLOAD, OP_HGET, OP_HREAD, OP_CWRITE, OP_CREAD, OP_WAIT} opT;

    logic     clk_dut;
    logic     reset;
    hostAddrT hostAddr;
    byteT     hostDin;
    logic     hostLoad;
    logic     hostGet;
    byteT     hostDout;
    cpuAddrT  cpuAddr;
    byteT     cpuDataOut;
    logic     cpuWe;
    byteT     cpuDataIn;

    opT      opQ[$];
    cpuAddrT addrQ[$];
    byteT    dataQ[$];
    byteT    expQ[$];
    bit      opsLoaded = 1'b0;

    apple1EmuTop DUT (
        .clk_dut    (clk_dut),
        .reset      (reset),
        .hostAddr   (hostAddr),
        .hostDin    (hostDin),
        .hostLoad   (hostLoad),
        .hostGet    (hostGet),
        .hostDout   (hostDout),
        .cpuAddr    (cpuAddr),
        .cpuDataOut (cpuDataOut),
        .cpuWe      (cpuWe),
        .cpuDataIn  (cpuDataIn)
    );

    always
    begin
        #(CLK_PERIOD / 2) clk_dut = ~clk_dut;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped after first error");
    endtask

    task automatic checkValue(input byteT actual, input byteT expected, input string what);
        if (actual !== expected)
            abortRun($sformatf("CHECK FAILED at %0t ns: %s expected %h, got %h",
                               $time, what, expected, actual));
    endtask

    task automatic loadStimulus();
        int                 fd;
        int                 n;
        logic [8*8-1:0]     opName;
        logic [8*128-1:0]   restOfLine;
        cpuAddrT            a;
        byteT               d;
        byteT               e;
        opT                 op;
        fd = $fopen("tests/apple1Stimulus.txt", "r");
        if (fd == 0)
            abortRun("Could not open the stimulus file tests/apple1Stimulus.txt");
        op = OP_WAIT;
        while ($fscanf(fd, "%s", opName) == 1)
        begin
            if (opName == "#")
            begin
                n = $fgets(restOfLine, fd); // Column notes
            end
            else
            begin
                n = $fscanf(fd, "%h %h %h", a, d, e);
                if (n != 3)
                    abortRun($sformatf("Stimulus line %0d has missing fields", opQ.size() + 1));
                case (opName)
                    "HSET":   op = OP_HSET;
                    "HLOAD":  op = OP_HLOAD;
                    "HGET":   op = OP_HGET;
                    "HREAD":  op = OP_HREAD;
                    "CWRITE": op = OP_CWRITE;
                    "CREAD":  op = OP_CREAD;
                    "WAIT":   op = OP_WAIT;
                    default:  abortRun($sformatf("Unknown operation %s in stimulus file", opName));
                endcase
                opQ.push_back(op);
                addrQ.push_back(a);
                dataQ.push_back(d);
                expQ.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // Each operation drives on one falling edge and samples or releases on the next
    task automatic runOp(input int idx);
        cpuAddrT addr;
        byteT    data;
        byteT    expected;
        string   tag;
        addr     = addrQ[idx];
        data     = dataQ[idx];
        expected = expQ[idx];
        tag      = $sformatf("op %0d", idx + 1);
        case (opQ[idx])
            OP_HSET:
            begin
                @(negedge clk_dut);
                hostAddr = addr[2:0];
                hostDin  = data;
                @(negedge clk_dut);
                hostAddr = IDLE_SLOT;
                hostDin  = '0;
            end
            OP_HLOAD:
            begin
                @(negedge clk_dut);
                hostLoad = 1'b1;
                @(negedge clk_dut);
                hostLoad = 1'b0;
            end
            OP_HGET:
            begin
                @(negedge clk_dut);
                hostGet = 1'b1;
                @(negedge clk_dut);
                hostGet = 1'b0;
            end
            OP_HREAD:
            begin
                @(negedge clk_dut);
                hostAddr = addr[2:0];
                hostDin  = data; // Same cycle also writes this stimulus slot
                @(negedge clk_dut);
                checkValue(hostDout, expected, {tag, " host readback"});
                hostAddr = IDLE_SLOT;
                hostDin  = '0;
            end
            OP_CWRITE:
            begin
                @(negedge clk_dut);
                cpuAddr    = addr;
                cpuDataOut = data;
                cpuWe      = 1'b1;
                @(negedge clk_dut);
                cpuWe      = 1'b0;
                cpuAddr    = IDLE_ADDR;
                cpuDataOut = '0;
            end
            OP_CREAD:
            begin
                @(negedge clk_dut);
                cpuAddr = addr;
                cpuWe   = 1'b0;
                @(negedge clk_dut);
                checkValue(cpuDataIn, expected, $sformatf("%s CPU read of %h", tag, addr));
                cpuAddr = IDLE_ADDR;
            end
            default:
            begin
                repeat (data) @(negedge clk_dut);
            end
        endcase
    endtask

    initial
    begin
        clk_dut    = 1'b0;
        reset      = 1'b1;
        hostAddr   = IDLE_SLOT;
        hostDin    = '0;
        hostLoad   = 1'b0;
        hostGet    = 1'b0;
        cpuAddr    = IDLE_ADDR;
        cpuDataOut = '0;
        cpuWe      = 1'b0;
        loadStimulus();
        opsLoaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk_dut);
        reset = 1'b0;
        for (int i = 0; i < opQ.size(); i++)
        begin
            runOp(i);
        end
        @(negedge clk_dut);
        $display("Simulation finished: PASS");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (opsLoaded);
        #((opQ.size() * CYCLES_PER_OP + RESET_CYCLES) * CLK_PERIOD);
        abortRun($sformatf("Timeout: the %0d operations did not finish in time", opQ.size()));
    end

endmodule

/* tests/apple1Stimulus.txt */
# op  addr  data  expect  (all hex; HSET/HREAD addr is a host slot, CREAD/CWRITE a CPU address)
# WAIT takes its cycle count from data; unused fields are 0
HGET   0    00 00
HREAD  0    00 00
HREAD  1    00 00
HREAD  2    00 00
HSET   2    03 00
HSET   3    12 00
HSET   4    34 00
HSET   5    A5 00
HLOAD  0    00 00
HSET   2    00 00
HLOAD  0    00 00
HSET   2    01 00
HLOAD  0    00 00
HGET   0    00 00
HREAD  3    00 A5
HSET   2    00 00
HLOAD  0    00 00
CWRITE 0300 3C 00
CREAD  0300 00 3C
HSET   2    01 00
HSET   3    03 00
HSET   4    00 00
HLOAD  0    00 00
HGET   0    00 00
HREAD  3    00 3C
HSET   1    C1 00
HSET   0    10 00
HLOAD  0    00 00
WAIT   0    08 00
CREAD  D011 00 80
CREAD  D010 00 C1
CREAD  D011 00 00
WAIT   0    08 00
CREAD  D011 00 00
CWRITE D012 41 00
HGET   0    00 00
HREAD  0    00 41
CWRITE D012 42 00
HGET   0    00 00
HREAD  0    00 41
CREAD  D012 00 41
HSET   0    20 00
HLOAD  0    00 00
HSET   0    00 00
HLOAD  0    00 00
HGET   0    00 00
HREAD  0    00 00
CWRITE D012 43 00
HGET   0    00 00
HREAD  0    00 43

/* all.f */
logic/apple1EmuPkg.sv
logic/hostTransactor.sv
logic/piaBusDecode.sv
logic/keyboardPort.sv
logic/displayPort.sv
logic/emuMemory.sv
logic/apple1EmuTop.sv
tests/apple1EmuTb.sv

/* Bender.yml */
package:
  name: apple1_emu

sources:
  - files:
      - logic/apple1EmuPkg.sv
      - logic/hostTransactor.sv
      - logic/piaBusDecode.sv
      - logic/keyboardPort.sv
      - logic/displayPort.sv
      - logic/emuMemory.sv
      - logic/apple1EmuTop.sv
  - target: test
    files:
      - tests/apple1EmuTb.sv
